// File: verif/eq_patterns.txt
# columns: name seed amplitude data_symbols expected_outputs max_gap
# a negative amplitude draws components in [amplitude, 0], max_gap 0 is back to back
basic        11      1000  2   96  0
gaps         2024    1500  2   96  3
negative     517    -2047  2   96  0
negative_gap 8191   -3000  1   48  2
large        999     4000  3  144  1
tiny         4242       3  1   48  0
second_pkt   31337    700  1   48  0

// File: list.f
common/eq_pkg.sv
channel_estimate/lts_estimator.sv
logic/conj_mult.sv
logic/complex_divider.sv
logic/carrier_select.sv
logic/equalizer_top.sv
verif/equalizer_chk.sv
verif/tb_equalizer.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_equalizer -f list.f
./obj_dir/Vtb_equalizer | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// File: verif/tb_equalizer.sv
`default_nettype none

module tb_equalizer
    import eq_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SCALE_SHIFT = 2;

    logic        clock;
    logic        reset;
    logic [31:0] sample_i;
    logic        sample_strobe_i;
    logic [31:0] sample_o;
    logic        sample_strobe_o;

    // one entry per line of the pattern file
    string test_name [$];
    int test_seed [$];
    int test_amp [$];
    int test_symbols [$];
    int test_expected [$];
    int test_gap [$];

    // expected outputs in arrival order
    logic [31:0] exp_word_q [$];
    int exp_cycle_q [$];
    int exp_sc_q [$];

    // reference model state
    int lts_i [NUM_SC];
    int lts_q [NUM_SC];
    int est_i [NUM_SC];
    int est_q [NUM_SC];

    int unsigned rng;
    string cur_name;
    int cycle_count;
    int cycle_limit;
    int out_count;
    int checks;
    int errors;

    equalizer_top #(
        .SCALE_SHIFT (SCALE_SHIFT)
    ) UUT (
        .clock           (clock),
        .reset           (reset),
        .sample_i        (sample_i),
        .sample_strobe_i (sample_strobe_i),
        .sample_o        (sample_o),
        .sample_strobe_o (sample_strobe_o)
    );

    always #4 clock = ~clock;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0s %0s: expected %h actual %h", cur_name, what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAIL %0s %0s: expected %0d actual %0d", cur_name, what, expected, actual);
        end
    endtask

    // negative amplitude keeps every component at or below zero
    task automatic draw_component(input int amp, output int value);
        int r;
        rng = lcg_next(rng);
        r = int'((rng >> 16) & 32'h7fff);
        if (amp > 0) begin
            value = r % (2 * amp + 1) - amp;
        end else if (amp < 0) begin
            value = -(r % (1 - amp));
        end else begin
            value = 0;
        end
    endtask

    task automatic model_sample(input int n, input int xi, input int xq, input int in_cycle);
        int sc;
        longint pi;
        longint pq;
        longint mag;
        longint qi;
        longint qq;
        sc = n % NUM_SC;
        if (n < NUM_SC) begin
            lts_i[sc] = xi;
            lts_q[sc] = xq;
        end else if (n < 2 * NUM_SC) begin
            // floor of the half-sum, then the reference sign
            est_i[sc] = (lts_i[sc] + xi) >>> 1;
            est_q[sc] = (lts_q[sc] + xq) >>> 1;
            if (LTS_REF[sc]) begin
                est_i[sc] = -est_i[sc];
                est_q[sc] = -est_q[sc];
            end
        end else if (DATA_SC_MASK[sc]) begin
            pi = longint'(xi) * est_i[sc] + longint'(xq) * est_q[sc];
            pq = longint'(xq) * est_i[sc] - longint'(xi) * est_q[sc];
            mag = longint'(est_i[sc]) * est_i[sc] + longint'(est_q[sc]) * est_q[sc];
            if (mag == 0) begin
                qi = 0;
                qq = 0;
            end else begin
                qi = (pi * (1 << SCALE_SHIFT)) / mag;
                qq = (pq * (1 << SCALE_SHIFT)) / mag;
            end
            exp_word_q.push_back({qi < 0, qi[14:0], qq < 0, qq[14:0]});
            exp_cycle_q.push_back(in_cycle);
            exp_sc_q.push_back(sc);
        end
    endtask

    task automatic load_patterns();
        int fd;
        int rc;
        string line;
        logic [8*24-1:0] name_buf;
        int seed, amp, symbols, expected, gap;
        fd = $fopen("verif/eq_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file verif/eq_patterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 0 && line[0] != 8'h23) begin
                rc = $sscanf(line, "%s %d %d %d %d %d", name_buf, seed, amp, symbols,
                             expected, gap);
                if (rc == 6) begin
                    test_name.push_back($sformatf("%0s", name_buf));
                    test_seed.push_back(seed);
                    test_amp.push_back(amp);
                    test_symbols.push_back(symbols);
                    test_expected.push_back(expected);
                    test_gap.push_back(gap);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        int total;
        int n;
        int idle;
        int waited;
        int xi, xq;
        cur_name = test_name[t];
        rng = 32'd73026 ^ test_seed[t];
        exp_word_q.delete();
        exp_cycle_q.delete();
        exp_sc_q.delete();
        @(negedge clock);
        reset = 1'b1;
        sample_strobe_i = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        out_count = 0;
        total = 2 * NUM_SC + NUM_SC * test_symbols[t];
        for (n = 0; n < total; n++) begin
            if (test_gap[t] > 0) begin
                rng = lcg_next(rng);
                idle = int'((rng >> 16) % (test_gap[t] + 1));
                repeat (idle) @(negedge clock);
            end
            draw_component(test_amp[t], xi);
            draw_component(test_amp[t], xq);
            sample_i = {xi[15:0], xq[15:0]};
            sample_strobe_i = 1'b1;
            // input and output strobes are both seen at a falling edge
            model_sample(n, xi, xq, cycle_count);
            @(negedge clock);
            sample_strobe_i = 1'b0;
        end
        waited = 0;
        while (exp_word_q.size() != 0 && waited < 2 * EQ_LAT) begin
            @(negedge clock);
            waited++;
        end
        if (exp_word_q.size() != 0) begin
            errors++;
            $display("test %0s: %0d expected outputs never appeared", cur_name,
                     exp_word_q.size());
        end
        // quiet window so that stray strobes still show up
        repeat (EQ_LAT) @(negedge clock);
        check_count("output count", test_expected[t], out_count);
        check_count("outputs for all data symbols", test_symbols[t] * NUM_DATA_SC, out_count);
    endtask

    always @(negedge clock) begin : watch_outputs
        logic [31:0] exp_word;
        int exp_cycle;
        int exp_sc;
        if (sample_strobe_o === 1'b1) begin
            out_count++;
            if (exp_word_q.size() == 0) begin
                errors++;
                $display("test %0s: output %h appeared with no data sample waiting for it",
                         cur_name, sample_o);
            end else begin
                exp_word = exp_word_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                exp_sc = exp_sc_q.pop_front();
                check_word($sformatf("word at subcarrier %0d", exp_sc), exp_word, sample_o);
                check_count($sformatf("output cycle at subcarrier %0d", exp_sc),
                            exp_cycle + EQ_LAT, cycle_count);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        sample_i = '0;
        sample_strobe_i = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        out_count = 0;
        checks = 0;
        errors = 0;
        cur_name = "setup";
        load_patterns();
        if (test_name.size() == 0) begin
            errors++;
            $display("no tests were found in the pattern file");
        end
        // worst case gap on every strobe, plus reset and drain per test
        cycle_limit = 200;
        foreach (test_name[t]) begin
            cycle_limit += (2 * NUM_SC + NUM_SC * test_symbols[t]) * (test_gap[t] + 1)
                           + 3 * EQ_LAT + 8;
        end
        foreach (test_name[t]) begin
            run_test(t);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/equalizer_chk.sv
`default_nettype none

module equalizer_chk
    import eq_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic       in_strobe_i,
    input logic       out_strobe_i,
    input est_state_t est_state_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // input strobes since reset, saturating
    logic [7:0] in_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            in_count <= '0;
        end else if (in_strobe_i && in_count != 8'hff) begin
            in_count <= in_count + 1'b1;
        end
    end

    assert property (@(posedge clock) reset |=> !out_strobe_i)
        else $error("output strobe in the cycle after reset");

    // both training symbols must be in before any output
    assert property (@(posedge clock) disable iff (reset) out_strobe_i |-> in_count > 8'd128)
        else $error("output strobe during the training symbols");

    assert property (@(posedge clock) disable iff (reset)
                     est_state_i == S_DATA |=> est_state_i == S_DATA)
        else $error("estimator left the data state without reset");

endmodule

bind equalizer_top equalizer_chk u_equalizer_chk (
    .clock        (clock),
    .reset        (reset),
    .in_strobe_i  (sample_strobe_i),
    .out_strobe_i (sample_strobe_o),
    .est_state_i  (u_lts_estimator.state)
);

`default_nettype wire

// File: logic/equalizer_top.sv
`default_nettype none

module equalizer_top
    import eq_pkg::*;
#(
    parameter int SCALE_SHIFT = 2
) (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] sample_i,
    input  logic        sample_strobe_i,
    output logic [31:0] sample_o,
    output logic        sample_strobe_o
);

    // estimator to multiplier
    logic signed [SAMPLE_W-1:0] est_data_i, est_data_q;
    logic signed [SAMPLE_W-1:0] est_i, est_q;
    logic [SC_IDX_W-1:0] est_index;
    logic est_strobe;

    // multiplier to divider
    logic signed [PROD_W-1:0] prod_i, prod_q;
    logic [PROD_W-1:0] mag_sq;
    logic [SC_IDX_W-1:0] mult_index;
    logic mult_strobe;

    // divider to carrier select
    logic signed [PROD_W-1:0] quot_i, quot_q;
    logic [SC_IDX_W-1:0] div_index;
    logic div_strobe;

    lts_estimator u_lts_estimator (
        .clock           (clock),
        .reset           (reset),
        .sample_i        (sample_i),
        .sample_strobe_i (sample_strobe_i),
        .data_i_o        (est_data_i),
        .data_q_o        (est_data_q),
        .est_i_o         (est_i),
        .est_q_o         (est_q),
        .index_o         (est_index),
        .strobe_o        (est_strobe)
    );

    conj_mult u_conj_mult (
        .clock    (clock),
        .reset    (reset),
        .data_i_i (est_data_i),
        .data_q_i (est_data_q),
        .est_i_i  (est_i),
        .est_q_i  (est_q),
        .index_i  (est_index),
        .strobe_i (est_strobe),
        .prod_i_o (prod_i),
        .prod_q_o (prod_q),
        .mag_sq_o (mag_sq),
        .index_o  (mult_index),
        .strobe_o (mult_strobe)
    );

    complex_divider #(
        .SCALE_SHIFT (SCALE_SHIFT)
    ) u_complex_divider (
        .clock    (clock),
        .reset    (reset),
        .prod_i_i (prod_i),
        .prod_q_i (prod_q),
        .mag_sq_i (mag_sq),
        .index_i  (mult_index),
        .strobe_i (mult_strobe),
        .quot_i_o (quot_i),
        .quot_q_o (quot_q),
        .index_o  (div_index),
        .strobe_o (div_strobe)
    );

    carrier_select u_carrier_select (
        .clock           (clock),
        .reset           (reset),
        .quot_i_i        (quot_i),
        .quot_q_i        (quot_q),
        .index_i         (div_index),
        .strobe_i        (div_strobe),
        .sample_o        (sample_o),
        .sample_strobe_o (sample_strobe_o)
    );

endmodule

`default_nettype wire

// File: logic/carrier_select.sv
`default_nettype none

module carrier_select
    import eq_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic signed [PROD_W-1:0] quot_i_i,
    input  logic signed [PROD_W-1:0] quot_q_i,
    input  logic [SC_IDX_W-1:0]      index_i,
    input  logic                     strobe_i,
    output logic [31:0]              sample_o,
    output logic                     sample_strobe_o
);

    logic is_data_sc;
    logic [15:0] packed_i, packed_q;

    // pilots, DC and guard bins are dropped here
    assign is_data_sc = DATA_SC_MASK[index_i];

    // sign bit on top of the low 15 bits
    assign packed_i = {quot_i_i[PROD_W-1], quot_i_i[14:0]};
    assign packed_q = {quot_q_i[PROD_W-1], quot_q_i[14:0]};

    always_ff @(posedge clock) begin
        sample_o <= {packed_i, packed_q};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            sample_strobe_o <= 1'b0;
        end else begin
            sample_strobe_o <= strobe_i && is_data_sc;
        end
    end

endmodule

`default_nettype wire

// File: logic/complex_divider.sv
`default_nettype none

module complex_divider
    import eq_pkg::*;
#(
    parameter int SCALE_SHIFT = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic signed [PROD_W-1:0] prod_i_i,
    input  logic signed [PROD_W-1:0] prod_q_i,
    input  logic [PROD_W-1:0]        mag_sq_i,
    input  logic [SC_IDX_W-1:0]      index_i,
    input  logic                     strobe_i,
    output logic signed [PROD_W-1:0] quot_i_o,
    output logic signed [PROD_W-1:0] quot_q_o,
    output logic [SC_IDX_W-1:0]      index_o,
    output logic                     strobe_o
);

    // one restoring step, returns {remainder, dividend bits and quotient bits}
    function automatic logic [2*PROD_W-1:0] div_step(
        input logic [PROD_W-1:0] rem,
        input logic [PROD_W-1:0] work,
        input logic [PROD_W-1:0] dvs
    );
        logic [PROD_W:0] trial;
        trial = {rem, work[PROD_W-1]};
        if (trial >= {1'b0, dvs}) begin
            return {PROD_W'(trial - {1'b0, dvs}), work[PROD_W-2:0], 1'b1};
        end
        return {trial[PROD_W-1:0], work[PROD_W-2:0], 1'b0};
    endfunction

    function automatic logic [PROD_W-1:0] magnitude(input logic signed [PROD_W-1:0] v);
        return v[PROD_W-1] ? PROD_W'(-v) : PROD_W'(v);
    endfunction

    logic signed [PROD_W-1:0] scaled_i, scaled_q;

    // index 0 is the input register, index s holds the state after s steps
    logic [PROD_W-1:0] rem_i [DIV_STAGES+1];
    logic [PROD_W-1:0] rem_q [DIV_STAGES+1];
    logic [PROD_W-1:0] work_i [DIV_STAGES+1];
    logic [PROD_W-1:0] work_q [DIV_STAGES+1];
    logic [PROD_W-1:0] divisor [DIV_STAGES+1];
    logic neg_i [DIV_STAGES+1];
    logic neg_q [DIV_STAGES+1];
    logic [SC_IDX_W-1:0] idx_pipe [DIV_STAGES+1];
    logic [DIV_STAGES:0] stb_pipe;

    assign scaled_i = prod_i_i <<< SCALE_SHIFT;
    assign scaled_q = prod_q_i <<< SCALE_SHIFT;

    always_ff @(posedge clock) begin
        rem_i[0] <= '0;
        rem_q[0] <= '0;
        work_i[0] <= magnitude(scaled_i);
        work_q[0] <= magnitude(scaled_q);
        divisor[0] <= mag_sq_i;
        neg_i[0] <= scaled_i[PROD_W-1];
        neg_q[0] <= scaled_q[PROD_W-1];
        idx_pipe[0] <= index_i;

        for (int s = 1; s <= DIV_STAGES; s++) begin
            {rem_i[s], work_i[s]} <= div_step(rem_i[s-1], work_i[s-1], divisor[s-1]);
            {rem_q[s], work_q[s]} <= div_step(rem_q[s-1], work_q[s-1], divisor[s-1]);
            divisor[s] <= divisor[s-1];
            neg_i[s] <= neg_i[s-1];
            neg_q[s] <= neg_q[s-1];
            idx_pipe[s] <= idx_pipe[s-1];
        end

        // sign fix-up, the estimate of a dead bin gives zero
        if (divisor[DIV_STAGES] == '0) begin
            quot_i_o <= '0;
            quot_q_o <= '0;
        end else begin
            quot_i_o <= neg_i[DIV_STAGES] ? -$signed(work_i[DIV_STAGES])
                                          : $signed(work_i[DIV_STAGES]);
            quot_q_o <= neg_q[DIV_STAGES] ? -$signed(work_q[DIV_STAGES])
                                          : $signed(work_q[DIV_STAGES]);
        end
        index_o <= idx_pipe[DIV_STAGES];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stb_pipe <= '0;
            strobe_o <= 1'b0;
        end else begin
            stb_pipe <= {stb_pipe[DIV_STAGES-1:0], strobe_i};
            strobe_o <= stb_pipe[DIV_STAGES];
        end
    end

endmodule

`default_nettype wire

// File: logic/conj_mult.sv
`default_nettype none

module conj_mult
    import eq_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic signed [SAMPLE_W-1:0] data_i_i,
    input  logic signed [SAMPLE_W-1:0] data_q_i,
    input  logic signed [SAMPLE_W-1:0] est_i_i,
    input  logic signed [SAMPLE_W-1:0] est_q_i,
    input  logic [SC_IDX_W-1:0]        index_i,
    input  logic                       strobe_i,
    output logic signed [PROD_W-1:0]   prod_i_o,
    output logic signed [PROD_W-1:0]   prod_q_o,
    output logic [PROD_W-1:0]          mag_sq_o,
    output logic [SC_IDX_W-1:0]        index_o,
    output logic                       strobe_o
);

    // stage one partial products
    logic signed [PROD_W-1:0] xi_hi, xq_hq, xq_hi, xi_hq;
    logic signed [PROD_W-1:0] hi_sq, hq_sq;
    logic [SC_IDX_W-1:0] index_d;
    logic strobe_d;

    always_ff @(posedge clock) begin
        xi_hi <= data_i_i * est_i_i;
        xq_hq <= data_q_i * est_q_i;
        xq_hi <= data_q_i * est_i_i;
        xi_hq <= data_i_i * est_q_i;
        hi_sq <= est_i_i * est_i_i;
        hq_sq <= est_q_i * est_q_i;
        index_d <= index_i;

        // x times conj(h)
        prod_i_o <= xi_hi + xq_hq;
        prod_q_o <= xq_hi - xi_hq;
        mag_sq_o <= $unsigned(hi_sq + hq_sq);
        index_o <= index_d;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            strobe_d <= 1'b0;
            strobe_o <= 1'b0;
        end else begin
            strobe_d <= strobe_i;
            strobe_o <= strobe_d;
        end
    end

endmodule

`default_nettype wire

// File: channel_estimate/lts_estimator.sv
`default_nettype none

module lts_estimator
    import eq_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic [31:0]                sample_i,
    input  logic                       sample_strobe_i,
    output logic signed [SAMPLE_W-1:0] data_i_o,
    output logic signed [SAMPLE_W-1:0] data_q_o,
    output logic signed [SAMPLE_W-1:0] est_i_o,
    output logic signed [SAMPLE_W-1:0] est_q_o,
    output logic [SC_IDX_W-1:0]        index_o,
    output logic                       strobe_o
);

    est_state_t state;
    logic [SC_IDX_W-1:0] idx_q;
    logic [SC_IDX_W-1:0] idx_d;
    logic mean_stb;

    // channel estimate per subcarrier, I high and Q low
    logic [31:0] est_ram [NUM_SC];
    logic [31:0] rd_word;
    logic [31:0] samp_q;

    logic ram_we;
    logic [SC_IDX_W-1:0] ram_waddr;
    logic [31:0] ram_wdata;

    logic signed [SAMPLE_W-1:0] old_i, old_q, new_i, new_q;
    logic signed [SAMPLE_W:0] sum_i, sum_q;
    logic signed [SAMPLE_W-1:0] half_i, half_q;
    logic signed [SAMPLE_W-1:0] mean_i, mean_q;

    assign old_i = rd_word[31:16];
    assign old_q = rd_word[15:0];
    assign new_i = samp_q[31:16];
    assign new_q = samp_q[15:0];

    // half-sum floors, the reference sign is applied afterwards
    assign sum_i = old_i + new_i;
    assign sum_q = old_q + new_q;
    assign half_i = sum_i[SAMPLE_W:1];
    assign half_q = sum_q[SAMPLE_W:1];
    assign mean_i = LTS_REF[idx_d] ? -half_i : half_i;
    assign mean_q = LTS_REF[idx_d] ? -half_q : half_q;

    // first LTS writes raw samples, second LTS writes the mean a cycle later
    assign ram_we = (state == S_FIRST_LTS && sample_strobe_i) || mean_stb;
    assign ram_waddr = mean_stb ? idx_d : idx_q;
    assign ram_wdata = mean_stb ? {mean_i, mean_q} : sample_i;

    always_ff @(posedge clock) begin
        if (ram_we) begin
            est_ram[ram_waddr] <= ram_wdata;
        end
        rd_word <= est_ram[idx_q];
        samp_q <= sample_i;
        idx_d <= idx_q;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_FIRST_LTS;
            idx_q <= '0;
            mean_stb <= 1'b0;
            strobe_o <= 1'b0;
        end else begin
            mean_stb <= sample_strobe_i && (state == S_SECOND_LTS);
            strobe_o <= sample_strobe_i && (state == S_DATA);
            if (sample_strobe_i) begin
                idx_q <= idx_q + 1'b1;
                if (idx_q == SC_IDX_W'(NUM_SC - 1)) begin
                    case (state)
                        S_FIRST_LTS:  state <= S_SECOND_LTS;
                        S_SECOND_LTS: state <= S_DATA;
                        default:      state <= S_DATA;
                    endcase
                end
            end
        end
    end

    assign data_i_o = samp_q[31:16];
    assign data_q_o = samp_q[15:0];
    assign est_i_o = rd_word[31:16];
    assign est_q_o = rd_word[15:0];
    assign index_o = idx_d;

endmodule

`default_nettype wire

// File: common/eq_pkg.sv
`default_nettype none

package eq_pkg;

    // one I or Q component
    localparam int SAMPLE_W = 16;

    // subcarriers per OFDM symbol
    localparam int NUM_SC = 64;
    localparam int SC_IDX_W = 6;

    // products, squared magnitude and quotients
    localparam int PROD_W = 32;

    // one quotient bit per divider stage
    localparam int DIV_STAGES = 32;

    // bit n belongs to subcarrier n: bit 0 is DC, bits 1..26 are +1..+26,
    // bits 38..63 are -26..-1
    localparam logic [NUM_SC-1:0] USED_SC_MASK =
        64'b1111111111111111111111111100000000000111111111111111111111111110;

    // pilots at -7, -21, +21, +7
    localparam logic [NUM_SC-1:0] PILOT_SC_MASK =
        64'b0000001000000000000010000000000000000000001000000000000010000000;

    localparam logic [NUM_SC-1:0] DATA_SC_MASK = USED_SC_MASK ^ PILOT_SC_MASK;

    localparam int NUM_DATA_SC = 48;

    // long training reference, a 1 means the symbol is -1 on that bin
    localparam logic [NUM_SC-1:0] LTS_REF =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    typedef enum logic [1:0] {
        S_FIRST_LTS,
        S_SECOND_LTS,
        S_DATA
    } est_state_t;

    // cycles from strobe in to strobe out per stage
    localparam int EST_LAT = 1;
    localparam int MULT_LAT = 2;
    localparam int DIV_LAT = DIV_STAGES + 2;
    localparam int SEL_LAT = 1;
    localparam int EQ_LAT = EST_LAT + MULT_LAT + DIV_LAT + SEL_LAT;

endpackage

`default_nettype wire
